// File: hdl/ddr_bridge_pkg.sv
package ddr_bridge_pkg;

    // app data path, one beat per command
    localparam int data_width = 128;
    localparam int addr_width = 29;
    localparam int id_width   = 4;
    localparam int strb_width = data_width / 8;

    localparam int cmd_depth = 4;  // queued commands
    localparam int rd_depth  = 4;  // queued read responses

    // command word: {rd, last, id, addr, wr_data, wr_strb}
    localparam int cmd_word_width = 2 + id_width + addr_width + data_width + strb_width;

    // read entry: {id, last, data}
    localparam int rd_entry_width = id_width + 1 + data_width;

    // controller opcodes
    typedef enum logic [2:0] {
        APP_WR = 3'd0,
        APP_RD = 3'd1
    } app_op_t;

    typedef enum logic [1:0] {
        S_IDLE,
        S_WRITE,
        S_READ_CMD,
        S_READ_WAIT
    } seq_state_t;

endpackage

// File: hdl/ram_cmd_if.sv
interface ram_cmd_if
    import ddr_bridge_pkg::*;
();

    logic                  valid;  // queue head holds a command
    logic                  rd;
    logic                  last;
    logic [id_width-1:0]   id;
    logic [addr_width-1:0] addr;
    logic [data_width-1:0] wr_data;
    logic [strb_width-1:0] wr_strb;
    logic                  take;   // one-cycle pop

    modport producer (
        output valid, rd, last, id, addr, wr_data, wr_strb,
        input  take
    );

    modport consumer (
        input  valid, rd, last, id, addr, wr_data, wr_strb,
        output take
    );

endinterface

// File: hdl/sync_fifo.sv
module sync_fifo #(
    parameter int width = 8,
    parameter int depth = 4
) (
    input  logic                         clk_if,
    input  logic                         resetn,
    input  logic                         wr_en,
    input  logic [width-1:0]             wr_data,
    input  logic                         rd_en,
    output logic [width-1:0]             rd_data,
    output logic                         empty,
    output logic                         full,
    output logic [$clog2(depth+1)-1:0]   count
);

    logic [width-1:0]         mem [depth];
    logic [$clog2(depth)-1:0] wr_ptr;
    logic [$clog2(depth)-1:0] rd_ptr;
    logic                     do_wr;
    logic                     do_rd;

    assign do_wr   = wr_en && !full;   // overflow dropped
    assign do_rd   = rd_en && !empty;
    assign empty   = (count == 0);
    assign full    = (count == depth);
    assign rd_data = mem[rd_ptr];      // head always visible

    always_ff @(posedge clk_if) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk_if) begin
        if (!resetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == depth - 1) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == depth - 1) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// File: hdl/cmd_accept.sv
module cmd_accept
    import ddr_bridge_pkg::*;
(
    input  logic                  clk_if,
    input  logic                  resetn,
    input  logic                  cmd_valid,
    output logic                  cmd_ready,
    input  logic                  cmd_rd,
    input  logic                  cmd_last,
    input  logic [id_width-1:0]   cmd_id,
    input  logic [addr_width-1:0] cmd_addr,
    input  logic [data_width-1:0] cmd_wr_data,
    input  logic [strb_width-1:0] cmd_wr_strb,
    ram_cmd_if.producer           cmd
);

    logic [data_width-1:0]     wdata_in;
    logic [strb_width-1:0]     wstrb_in;
    logic [cmd_word_width-1:0] in_word;
    logic [cmd_word_width-1:0] head_word;
    logic                      q_full;
    logic                      q_empty;

    // reads carry no payload
    always_comb begin
        wdata_in = cmd_wr_data;
        wstrb_in = cmd_wr_strb;
        if (cmd_rd) begin
            wdata_in = '0;
            wstrb_in = '0;
        end
    end

    assign in_word = {cmd_rd, cmd_last, cmd_id, cmd_addr, wdata_in, wstrb_in};

    sync_fifo #(
        .width (cmd_word_width),
        .depth (cmd_depth)
    ) u_cmd_fifo (
        .clk_if  (clk_if),
        .resetn  (resetn),
        .wr_en   (cmd_valid && cmd_ready),
        .wr_data (in_word),
        .rd_en   (cmd.take),
        .rd_data (head_word),
        .empty   (q_empty),
        .full    (q_full),
        .count   ()
    );

    assign cmd_ready = !q_full;
    assign cmd.valid = !q_empty;
    assign {cmd.rd, cmd.last, cmd.id, cmd.addr, cmd.wr_data, cmd.wr_strb} = head_word;

endmodule

// File: hdl/app_sequencer.sv
module app_sequencer
    import ddr_bridge_pkg::*;
(
    input  logic                  clk_if,
    input  logic                  resetn,
    ram_cmd_if.consumer           cmd,
    output app_op_t               app_cmd,
    output logic                  app_cmd_en,
    output logic [addr_width-1:0] app_addr,
    input  logic                  app_cmd_ready,
    output logic [data_width-1:0] app_wdf_data,
    output logic                  app_wdf_wren,
    output logic                  app_wdf_end,
    output logic [strb_width-1:0] app_wdf_mask,
    input  logic                  app_wdf_rdy,
    input  logic [data_width-1:0] app_rd_data,
    input  logic                  app_rd_data_valid,
    output logic                  push,
    output logic [id_width-1:0]   push_id,
    output logic                  push_last,
    output logic [data_width-1:0] push_data,
    input  logic                  space
);

    seq_state_t          state;
    logic                cmd_hit;
    logic                wdf_hit;
    logic                cmd_ok;   // write command taken
    logic                wdf_ok;   // write data taken
    logic [id_width-1:0] id_q;
    logic                last_q;

    assign cmd_hit     = app_cmd_en && app_cmd_ready;
    assign wdf_hit     = app_wdf_wren && app_wdf_rdy;
    assign app_wdf_end = 1'b1;  // single beat

    // a read waits for a free response slot
    assign cmd.take = (state == S_IDLE) && cmd.valid && (!cmd.rd || space);

    always_ff @(posedge clk_if) begin
        if (!resetn) begin
            state        <= S_IDLE;
            app_cmd_en   <= 1'b0;
            app_wdf_wren <= 1'b0;
            cmd_ok       <= 1'b0;
            wdf_ok       <= 1'b0;
            push         <= 1'b0;
        end else begin
            push <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (cmd.take) begin
                        app_cmd_en <= 1'b1;
                        if (cmd.rd) begin
                            state <= S_READ_CMD;
                        end else begin
                            app_wdf_wren <= 1'b1;
                            state        <= S_WRITE;
                        end
                    end
                end
                S_WRITE: begin
                    // command and data may be taken on different edges
                    if (cmd_hit) begin
                        app_cmd_en <= 1'b0;
                        cmd_ok     <= 1'b1;
                    end
                    if (wdf_hit) begin
                        app_wdf_wren <= 1'b0;
                        wdf_ok       <= 1'b1;
                    end
                    if ((cmd_ok || cmd_hit) && (wdf_ok || wdf_hit)) begin
                        cmd_ok <= 1'b0;
                        wdf_ok <= 1'b0;
                        state  <= S_IDLE;
                    end
                end
                S_READ_CMD: begin
                    if (cmd_hit) begin
                        app_cmd_en <= 1'b0;
                        state      <= S_READ_WAIT;
                    end
                end
                S_READ_WAIT: begin
                    if (app_rd_data_valid) begin
                        push  <= 1'b1;
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_if) begin
        if (cmd.take) begin
            app_cmd      <= cmd.rd ? APP_RD : APP_WR;
            app_addr     <= cmd.addr;
            app_wdf_data <= cmd.wr_data;
            app_wdf_mask <= ~cmd.wr_strb;  // mask is active high
            id_q         <= cmd.id;
            last_q       <= cmd.last;
        end
        if (state == S_READ_WAIT && app_rd_data_valid) begin
            push_id   <= id_q;
            push_last <= last_q;
            push_data <= app_rd_data;
        end
    end

endmodule

// File: hdl/rd_resp_stage.sv
module rd_resp_stage
    import ddr_bridge_pkg::*;
(
    input  logic                  clk_if,
    input  logic                  resetn,
    input  logic                  push,
    input  logic [id_width-1:0]   push_id,
    input  logic                  push_last,
    input  logic [data_width-1:0] push_data,
    output logic                  space,
    output logic                  rd_resp_valid,
    input  logic                  rd_resp_ready,
    output logic [id_width-1:0]   rd_resp_id,
    output logic                  rd_resp_last,
    output logic [data_width-1:0] rd_resp_data
);

    logic [rd_entry_width-1:0]        head;
    logic                             q_empty;
    logic                             load;
    logic                             take_out;
    logic [$clog2(rd_depth+1)-1:0]    held;  // entries in queue and output reg

    sync_fifo #(
        .width (rd_entry_width),
        .depth (rd_depth)
    ) u_rd_fifo (
        .clk_if  (clk_if),
        .resetn  (resetn),
        .wr_en   (push),
        .wr_data ({push_id, push_last, push_data}),
        .rd_en   (load),
        .rd_data (head),
        .empty   (q_empty),
        .full    (),
        .count   ()
    );

    assign take_out = rd_resp_valid && rd_resp_ready;
    assign load     = !q_empty && (!rd_resp_valid || rd_resp_ready);

    // at most one read in flight, and its slot is claimed
    // through the push strobe before held catches up
    assign space = (held + push) < rd_depth;

    always_ff @(posedge clk_if) begin
        if (!resetn) begin
            held          <= '0;
            rd_resp_valid <= 1'b0;
        end else begin
            case ({push, take_out})
                2'b10:   held <= held + 1'b1;
                2'b01:   held <= held - 1'b1;
                default: held <= held;
            endcase
            if (load) begin
                rd_resp_valid <= 1'b1;
            end else if (take_out) begin
                rd_resp_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_if) begin
        if (load) begin
            {rd_resp_id, rd_resp_last, rd_resp_data} <= head;
        end
    end

endmodule

// File: hdl/ddr_bridge_top.sv
module ddr_bridge_top
    import ddr_bridge_pkg::*;
(
    input  logic                  clk_if,
    input  logic                  resetn,

    input  logic                  cmd_valid,
    output logic                  cmd_ready,
    input  logic                  cmd_rd,
    input  logic                  cmd_last,
    input  logic [id_width-1:0]   cmd_id,
    input  logic [addr_width-1:0] cmd_addr,
    input  logic [data_width-1:0] cmd_wr_data,
    input  logic [strb_width-1:0] cmd_wr_strb,

    output logic                  rd_resp_valid,
    input  logic                  rd_resp_ready,
    output logic [id_width-1:0]   rd_resp_id,
    output logic                  rd_resp_last,
    output logic [data_width-1:0] rd_resp_data,

    output app_op_t               app_cmd,
    output logic                  app_cmd_en,
    output logic [addr_width-1:0] app_addr,
    input  logic                  app_cmd_ready,
    output logic [data_width-1:0] app_wdf_data,
    output logic                  app_wdf_wren,
    output logic                  app_wdf_end,
    output logic [strb_width-1:0] app_wdf_mask,
    input  logic                  app_wdf_rdy,
    input  logic [data_width-1:0] app_rd_data,
    input  logic                  app_rd_data_valid
);

    ram_cmd_if cmd_bus ();

    logic                  rd_push;
    logic [id_width-1:0]   rd_push_id;
    logic                  rd_push_last;
    logic [data_width-1:0] rd_push_data;
    logic                  rd_space;

    cmd_accept u_cmd_accept (
        .clk_if      (clk_if),
        .resetn      (resetn),
        .cmd_valid   (cmd_valid),
        .cmd_ready   (cmd_ready),
        .cmd_rd      (cmd_rd),
        .cmd_last    (cmd_last),
        .cmd_id      (cmd_id),
        .cmd_addr    (cmd_addr),
        .cmd_wr_data (cmd_wr_data),
        .cmd_wr_strb (cmd_wr_strb),
        .cmd         (cmd_bus.producer)
    );

    app_sequencer u_app_sequencer (
        .clk_if            (clk_if),
        .resetn            (resetn),
        .cmd               (cmd_bus.consumer),
        .app_cmd           (app_cmd),
        .app_cmd_en        (app_cmd_en),
        .app_addr          (app_addr),
        .app_cmd_ready     (app_cmd_ready),
        .app_wdf_data      (app_wdf_data),
        .app_wdf_wren      (app_wdf_wren),
        .app_wdf_end       (app_wdf_end),
        .app_wdf_mask      (app_wdf_mask),
        .app_wdf_rdy       (app_wdf_rdy),
        .app_rd_data       (app_rd_data),
        .app_rd_data_valid (app_rd_data_valid),
        .push              (rd_push),
        .push_id           (rd_push_id),
        .push_last         (rd_push_last),
        .push_data         (rd_push_data),
        .space             (rd_space)
    );

    rd_resp_stage u_rd_resp_stage (
        .clk_if        (clk_if),
        .resetn        (resetn),
        .push          (rd_push),
        .push_id       (rd_push_id),
        .push_last     (rd_push_last),
        .push_data     (rd_push_data),
        .space         (rd_space),
        .rd_resp_valid (rd_resp_valid),
        .rd_resp_ready (rd_resp_ready),
        .rd_resp_id    (rd_resp_id),
        .rd_resp_last  (rd_resp_last),
        .rd_resp_data  (rd_resp_data)
    );

endmodule

// File: sim/ddr_app_model.sv
module ddr_app_model
    import ddr_bridge_pkg::*;
(
    input  logic                  clk_if,
    input  logic                  resetn,
    input  app_op_t               app_cmd,
    input  logic                  app_cmd_en,
    input  logic [addr_width-1:0] app_addr,
    output logic                  app_cmd_ready,
    input  logic [data_width-1:0] app_wdf_data,
    input  logic                  app_wdf_wren,
    input  logic [strb_width-1:0] app_wdf_mask,
    output logic                  app_wdf_rdy,
    output logic [data_width-1:0] app_rd_data,
    output logic                  app_rd_data_valid
);

    timeunit 1ns;
    timeprecision 1ps;

    logic [data_width-1:0] mem [logic [addr_width-1:0]];  // sparse, unwritten reads as zero

    integer                seed = 182;
    logic                  wr_cmd_seen;
    logic                  wr_dat_seen;
    logic [addr_width-1:0] wr_addr;
    logic [data_width-1:0] wr_data;
    logic [strb_width-1:0] wr_mask;
    logic [data_width-1:0] word;
    logic                  rd_busy;
    int                    rd_wait;
    logic [data_width-1:0] rd_buf;

    // handshakes are decided at the falling edge, both sides stable there
    initial begin
        app_cmd_ready     = 1'b0;
        app_wdf_rdy       = 1'b0;
        app_rd_data       = '0;
        app_rd_data_valid = 1'b0;
        wr_cmd_seen       = 1'b0;
        wr_dat_seen       = 1'b0;
        rd_busy           = 1'b0;
        rd_wait           = 0;
        forever begin
            @(negedge clk_if);
            app_rd_data_valid = 1'b0;
            if (!resetn) begin
                app_cmd_ready = 1'b0;
                app_wdf_rdy   = 1'b0;
                wr_cmd_seen   = 1'b0;
                wr_dat_seen   = 1'b0;
                rd_busy       = 1'b0;
            end else begin
                if (rd_busy) begin
                    if (rd_wait == 0) begin
                        app_rd_data       = rd_buf;
                        app_rd_data_valid = 1'b1;
                        rd_busy           = 1'b0;
                    end else begin
                        rd_wait--;
                    end
                end
                app_cmd_ready = ($random(seed) & 3) != 0;
                app_wdf_rdy   = ($random(seed) & 3) != 0;
                if (app_cmd_en && app_cmd_ready) begin
                    if (app_cmd == APP_RD) begin
                        rd_buf  = mem.exists(app_addr) ? mem[app_addr] : '0;
                        rd_wait = 1 + ($random(seed) & 7);  // 2 to 9 cycles
                        rd_busy = 1'b1;
                    end else begin
                        wr_addr     = app_addr;
                        wr_cmd_seen = 1'b1;
                    end
                end
                if (app_wdf_wren && app_wdf_rdy) begin
                    wr_data     = app_wdf_data;
                    wr_mask     = app_wdf_mask;
                    wr_dat_seen = 1'b1;
                end
                if (wr_cmd_seen && wr_dat_seen) begin
                    word = mem.exists(wr_addr) ? mem[wr_addr] : '0;
                    for (int b = 0; b < strb_width; b++) begin
                        if (!wr_mask[b]) begin
                            word[8*b +: 8] = wr_data[8*b +: 8];
                        end
                    end
                    mem[wr_addr] = word;
                    wr_cmd_seen  = 1'b0;
                    wr_dat_seen  = 1'b0;
                end
            end
        end
    end

endmodule

// File: sim/tb_ddr_bridge.sv
module tb_ddr_bridge
    import ddr_bridge_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int stall_len = 10;   // trailing reads run with rd_resp_ready held low
    localparam int stall_max = 200;  // longest hold of rd_resp_ready

    logic                  clk_if;
    logic                  resetn;
    logic                  cmd_valid;
    logic                  cmd_ready;
    logic                  cmd_rd;
    logic                  cmd_last;
    logic [id_width-1:0]   cmd_id;
    logic [addr_width-1:0] cmd_addr;
    logic [data_width-1:0] cmd_wr_data;
    logic [strb_width-1:0] cmd_wr_strb;
    logic                  rd_resp_valid;
    logic                  rd_resp_ready;
    logic [id_width-1:0]   rd_resp_id;
    logic                  rd_resp_last;
    logic [data_width-1:0] rd_resp_data;
    app_op_t               app_cmd;
    logic                  app_cmd_en;
    logic [addr_width-1:0] app_addr;
    logic                  app_cmd_ready;
    logic [data_width-1:0] app_wdf_data;
    logic                  app_wdf_wren;
    logic                  app_wdf_end;
    logic [strb_width-1:0] app_wdf_mask;
    logic                  app_wdf_rdy;
    logic [data_width-1:0] app_rd_data;
    logic                  app_rd_data_valid;

    logic [7:0]            t_op   [$];
    logic [id_width-1:0]   t_id   [$];
    logic                  t_last [$];
    logic [addr_width-1:0] t_addr [$];
    logic [data_width-1:0] t_data [$];
    logic [strb_width-1:0] t_strb [$];
    logic [data_width-1:0] t_exp  [$];

    logic [id_width+data_width:0] sb_q [$];  // {id, last, data} per pending read

    integer seed         = 182;
    int     limit        = 0;
    int     reads_total  = 0;
    int     resp_seen    = 0;
    int     low_cycles   = 0;
    int     stall_cycles = 0;
    logic   stall_phase  = 1'b0;
    logic   released     = 1'b0;
    logic   saw_full     = 1'b0;

    ddr_bridge_top u_ddr_bridge_top (
        .clk_if            (clk_if),
        .resetn            (resetn),
        .cmd_valid         (cmd_valid),
        .cmd_ready         (cmd_ready),
        .cmd_rd            (cmd_rd),
        .cmd_last          (cmd_last),
        .cmd_id            (cmd_id),
        .cmd_addr          (cmd_addr),
        .cmd_wr_data       (cmd_wr_data),
        .cmd_wr_strb       (cmd_wr_strb),
        .rd_resp_valid     (rd_resp_valid),
        .rd_resp_ready     (rd_resp_ready),
        .rd_resp_id        (rd_resp_id),
        .rd_resp_last      (rd_resp_last),
        .rd_resp_data      (rd_resp_data),
        .app_cmd           (app_cmd),
        .app_cmd_en        (app_cmd_en),
        .app_addr          (app_addr),
        .app_cmd_ready     (app_cmd_ready),
        .app_wdf_data      (app_wdf_data),
        .app_wdf_wren      (app_wdf_wren),
        .app_wdf_end       (app_wdf_end),
        .app_wdf_mask      (app_wdf_mask),
        .app_wdf_rdy       (app_wdf_rdy),
        .app_rd_data       (app_rd_data),
        .app_rd_data_valid (app_rd_data_valid)
    );

    ddr_app_model u_app_model (
        .clk_if            (clk_if),
        .resetn            (resetn),
        .app_cmd           (app_cmd),
        .app_cmd_en        (app_cmd_en),
        .app_addr          (app_addr),
        .app_cmd_ready     (app_cmd_ready),
        .app_wdf_data      (app_wdf_data),
        .app_wdf_wren      (app_wdf_wren),
        .app_wdf_mask      (app_wdf_mask),
        .app_wdf_rdy       (app_wdf_rdy),
        .app_rd_data       (app_rd_data),
        .app_rd_data_valid (app_rd_data_valid)
    );

    task automatic stop_run();
        $display("TEST RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [data_width-1:0] got,
                               input logic [data_width-1:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
            stop_run();
        end
    endtask

    task automatic load_tests();
        int                    fd;
        int                    n;
        string                 line;
        logic [7:0]            op;
        logic [id_width-1:0]   id;
        logic                  last;
        logic [addr_width-1:0] addr;
        logic [data_width-1:0] data;
        logic [strb_width-1:0] strb;
        logic [data_width-1:0] exp;
        fd = $fopen("sim/bridge_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open sim/bridge_tests.txt");
            stop_run();
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line[0] == "#") begin
                continue;
            end
            n = $sscanf(line, "%c %h %h %h %h %h %h", op, id, last, addr, data, strb, exp);
            if (n != 7 || (op != "W" && op != "R")) begin
                $display("malformed line in test file: %s", line);
                stop_run();
            end
            t_op.push_back(op);
            t_id.push_back(id);
            t_last.push_back(last);
            t_addr.push_back(addr);
            t_data.push_back(data);
            t_strb.push_back(strb);
            t_exp.push_back(exp);
            if (op == "R") begin
                reads_total++;
            end
        end
        $fclose(fd);
        limit = 64 * t_op.size() + 100;
    endtask

    // called on a falling edge, returns on the falling edge after the transfer
    task automatic send_cmd(input int i);
        cmd_valid   = 1'b1;
        cmd_rd      = (t_op[i] == "R");
        cmd_last    = t_last[i];
        cmd_id      = t_id[i];
        cmd_addr    = t_addr[i];
        cmd_wr_data = t_data[i];
        cmd_wr_strb = t_strb[i];
        while (!cmd_ready) begin
            @(negedge clk_if);
        end
        if (cmd_rd) begin
            sb_q.push_back({t_id[i], t_last[i], t_exp[i]});
        end
        @(negedge clk_if);
    endtask

    initial begin
        clk_if = 1'b0;
        forever #2 clk_if = ~clk_if;
    end

    initial begin
        resetn      = 1'b0;
        cmd_valid   = 1'b0;
        cmd_rd      = 1'b0;
        cmd_last    = 1'b0;
        cmd_id      = '0;
        cmd_addr    = '0;
        cmd_wr_data = '0;
        cmd_wr_strb = '0;
        load_tests();
        repeat (3) @(negedge clk_if);
        resetn = 1'b1;
        @(negedge clk_if);
        check_value("cmd_ready", cmd_ready, 1);
        check_value("rd_resp_valid", rd_resp_valid, 0);
        check_value("app_cmd_en", app_cmd_en, 0);
        check_value("app_wdf_wren", app_wdf_wren, 0);
        for (int i = 0; i < t_op.size(); i++) begin
            if (i == t_op.size() - stall_len) begin
                stall_phase = 1'b1;
            end
            send_cmd(i);
        end
        cmd_valid = 1'b0;
        while (resp_seen < reads_total) begin
            @(negedge clk_if);
        end
        if (!saw_full) begin
            $display("cmd_ready never dropped while responses were held back");
            stop_run();
        end else begin
            $display("TEST RESULT: PASS");
            $finish;
        end
    end

    // response side, ready drive and checks share one falling edge
    initial begin
        logic                         hold_prev;
        logic [id_width+data_width:0] prev_resp;
        logic [id_width+data_width:0] expect_resp;
        hold_prev     = 1'b0;
        prev_resp     = '0;
        rd_resp_ready = 1'b0;
        forever begin
            @(negedge clk_if);
            if (!resetn) begin
                rd_resp_ready = 1'b0;
            end else if (stall_phase && !released) begin
                rd_resp_ready = 1'b0;
                stall_cycles++;
                if (!cmd_ready) begin
                    low_cycles++;
                    saw_full = 1'b1;
                end
                if (low_cycles >= 16 || stall_cycles >= stall_max) begin
                    released = 1'b1;
                end
            end else begin
                rd_resp_ready = ($random(seed) & 3) != 0;
            end
            if (app_wdf_wren) begin  // single-beat writes
                check_value("app_wdf_end", app_wdf_end, 1);
            end
            if (hold_prev) begin  // stalled response must not move
                check_value("rd_resp_valid", rd_resp_valid, 1);
                check_value("rd_resp_id", rd_resp_id, prev_resp[data_width+1 +: id_width]);
                check_value("rd_resp_last", rd_resp_last, prev_resp[data_width]);
                check_value("rd_resp_data", rd_resp_data, prev_resp[data_width-1:0]);
            end
            if (rd_resp_valid && rd_resp_ready) begin
                if (sb_q.size() == 0) begin
                    $display("read response arrived with no read pending");
                    stop_run();
                end
                expect_resp = sb_q.pop_front();
                check_value("rd_resp_id", rd_resp_id, expect_resp[data_width+1 +: id_width]);
                check_value("rd_resp_last", rd_resp_last, expect_resp[data_width]);
                check_value("rd_resp_data", rd_resp_data, expect_resp[data_width-1:0]);
                resp_seen++;
            end
            hold_prev = rd_resp_valid && !rd_resp_ready;
            prev_resp = {rd_resp_id, rd_resp_last, rd_resp_data};
        end
    end

    initial begin
        int cycles;
        cycles = 0;
        wait (limit > 0);
        while (cycles < limit) begin
            @(posedge clk_if);
            cycles++;
        end
        $display("timeout, run did not finish within %0d cycles", limit);
        stop_run();
    end

endmodule

// File: sim/bridge_tests.txt
# op id last addr data strb expected, all fields but op in hex
# data and strb unused on reads, expected unused on writes; last ten lines run under back-pressure
W 1 1 00000100 0123456789abcdeffedcba9876543210 ffff 0
R 2 1 00000100 0 0 0123456789abcdeffedcba9876543210
W 3 0 00000200 11111111222222223333333344444444 ffff 0
W 4 1 00000200 aaaaaaaabbbbbbbbccccccccdddddddd 00ff 0
R 5 0 00000200 0 0 1111111122222222ccccccccdddddddd
W 6 1 00000200 deadbeef0123456789abcdef76543210 f000 0
R 7 1 00000200 0 0 deadbeef22222222ccccccccdddddddd
W 8 1 00000300 00001111222233334444555566667777 ffff 0
W 9 0 00000308 89abcdef89abcdef0011223344556677 ffff 0
R a 0 00000300 0 0 00001111222233334444555566667777
R b 1 00000308 0 0 89abcdef89abcdef0011223344556677
W d 1 00000308 ffffffffffffffffffffffffffffffff 8421 0
R e 0 00000308 0 0 ffabcdef89ffcdef0011ff33445566ff
R c 1 00000100 0 0 0123456789abcdeffedcba9876543210
R 3 0 00000100 0 0 0123456789abcdeffedcba9876543210
R 4 1 00000200 0 0 deadbeef22222222ccccccccdddddddd
R 5 0 00000300 0 0 00001111222233334444555566667777
R 6 1 00000308 0 0 ffabcdef89ffcdef0011ff33445566ff
R 7 0 00000100 0 0 0123456789abcdeffedcba9876543210
R 8 1 00000200 0 0 deadbeef22222222ccccccccdddddddd
R 9 0 00000300 0 0 00001111222233334444555566667777
R a 1 00000308 0 0 ffabcdef89ffcdef0011ff33445566ff
R b 0 00000100 0 0 0123456789abcdeffedcba9876543210
R c 1 00000200 0 0 deadbeef22222222ccccccccdddddddd

// File: compile.f
hdl/ddr_bridge_pkg.sv
hdl/ram_cmd_if.sv
hdl/sync_fifo.sv
hdl/cmd_accept.sv
hdl/app_sequencer.sv
hdl/rd_resp_stage.sv
hdl/ddr_bridge_top.sv
sim/ddr_app_model.sv
sim/tb_ddr_bridge.sv

// File: Makefile
TOP = tb_ddr_bridge

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -Wno-fatal -f compile.f --top-module $(TOP)

run: build
	./obj_dir/V$(TOP) | tee sim.log
	@grep -q "^TEST RESULT: PASS$$" sim.log

lint:
	verilator --lint-only --timing -Wall -f compile.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log
